// ==== icache_pkg.sv ====
package icache_pkg;

  // Byte address and line word
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;

  // One 64-bit word per line
  localparam int OFFSET_W = 3;

  localparam int NUM_LINES = 8;
  localparam int INDEX_W = $clog2(NUM_LINES);

  // Tag bits kept per line
  localparam int LINE_TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  // Line number as the byte address without its offset
  localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;

  // Memory transaction tags where zero is reserved for "none"
  localparam int NUM_MEM_TAGS = 16;
  localparam int MEM_TAG_W = 4;

  // Command toward instruction memory
  typedef enum logic [1:0] {
    BUS_NONE = 2'h0,
    BUS_LOAD = 2'h1
  } mem_cmd_e;

  // State of one outstanding transaction entry
  typedef enum logic {
    TRANS_IDLE    = 1'b0,
    TRANS_PENDING = 1'b1
  } trans_state_e;

endpackage

// ==== icache_lines.sv ====
`timescale 1ns/10ps

module icache_lines (
  input  logic                                i_clock,
  input  logic                                i_reset,
  input  logic [icache_pkg::ADDR_W-1:0]       i_lookup_addr,
  input  logic [icache_pkg::MEM_TAG_W-1:0]    i_issue_tag,
  input  logic [icache_pkg::INDEX_W-1:0]      i_issue_index,
  input  logic [icache_pkg::LINE_TAG_W-1:0]   i_issue_line_tag,
  input  logic                                i_fill_en,
  input  logic [icache_pkg::INDEX_W-1:0]      i_fill_index,
  input  logic [icache_pkg::LINE_TAG_W-1:0]   i_fill_tag,
  input  logic [icache_pkg::DATA_W-1:0]       i_fill_data,
  output logic [icache_pkg::INDEX_W-1:0]      o_index,
  output logic [icache_pkg::LINE_TAG_W-1:0]   o_line_tag,
  output logic                                o_hit,
  output logic [icache_pkg::DATA_W-1:0]       o_data
);

  logic [icache_pkg::NUM_LINES-1:0]  line_valid;
  logic [icache_pkg::LINE_TAG_W-1:0] line_tag  [icache_pkg::NUM_LINES];
  logic [icache_pkg::DATA_W-1:0]     line_data [icache_pkg::NUM_LINES];
  logic                              tag_match;
  logic                              issue_en;
  logic [icache_pkg::LINE_TAG_W-1:0] fill_line_tag;
  logic                              fill_ok;

  assign o_index    = i_lookup_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
  assign o_line_tag = i_lookup_addr[icache_pkg::ADDR_W-1 -: icache_pkg::LINE_TAG_W];

  assign tag_match = line_tag[o_index] == o_line_tag;
  assign o_hit     = line_valid[o_index] && tag_match;
  assign o_data    = line_data[o_index];

  // An accepted request claims its line for the requested tag
  assign issue_en = i_issue_tag != '0;

  // Tag the fill line will hold after this edge
  always_comb begin
    fill_line_tag = line_tag[i_fill_index];
    if (!o_hit && o_index == i_fill_index) begin
      fill_line_tag = o_line_tag;
    end
    if (issue_en && i_issue_index == i_fill_index) begin
      fill_line_tag = i_issue_line_tag;
    end
  end

  // Stale fills for a retagged line fall out here
  assign fill_ok = i_fill_en && (fill_line_tag == i_fill_tag);

  always_ff @(posedge i_clock) begin
    for (int i = 0; i < icache_pkg::NUM_LINES; i++) begin
      if (i_reset) begin
        line_valid[i] <= 1'b0;
      end else if (fill_ok && i_fill_index == icache_pkg::INDEX_W'(i)) begin
        line_valid[i] <= 1'b1;
      end else if ((!o_hit && o_index == icache_pkg::INDEX_W'(i)) ||
                   (issue_en && i_issue_index == icache_pkg::INDEX_W'(i))) begin
        line_valid[i] <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (!o_hit) begin
      line_tag[o_index] <= o_line_tag;
    end
    if (issue_en) begin
      line_tag[i_issue_index] <= i_issue_line_tag;
    end
  end

  always_ff @(posedge i_clock) begin
    if (fill_ok) begin
      line_data[i_fill_index] <= i_fill_data;
    end
  end

  // Every line comes out of reset invalid
  a_no_hit_after_reset: assert property (
    @(posedge i_clock) $fell(i_reset) |-> !o_hit
  ) else $error("icache_lines: hit in first cycle after reset");

endmodule

// ==== mem_tag_table.sv ====
`timescale 1ns/10ps

module mem_tag_table (
  input  logic                                i_clock,
  input  logic                                i_reset,
  input  logic [icache_pkg::MEM_TAG_W-1:0]    i_issue_tag,
  input  logic [icache_pkg::INDEX_W-1:0]      i_issue_index,
  input  logic [icache_pkg::LINE_TAG_W-1:0]   i_issue_line_tag,
  input  logic [icache_pkg::MEM_TAG_W-1:0]    i_mem_tag,
  input  logic [icache_pkg::DATA_W-1:0]       i_mem_data,
  output logic                                o_fill_en,
  output logic [icache_pkg::INDEX_W-1:0]      o_fill_index,
  output logic [icache_pkg::LINE_TAG_W-1:0]   o_fill_tag,
  output logic [icache_pkg::DATA_W-1:0]       o_fill_data
);

  icache_pkg::trans_state_e          entry_state [icache_pkg::NUM_MEM_TAGS];
  logic [icache_pkg::INDEX_W-1:0]    entry_index [icache_pkg::NUM_MEM_TAGS];
  logic [icache_pkg::LINE_TAG_W-1:0] entry_tag   [icache_pkg::NUM_MEM_TAGS];
  logic                              issue_en;

  assign issue_en = i_issue_tag != '0;

  // Returning data is looked up by its tag in the same cycle
  assign o_fill_en    = (i_mem_tag != '0) &&
                        (entry_state[i_mem_tag] == icache_pkg::TRANS_PENDING);
  assign o_fill_index = entry_index[i_mem_tag];
  assign o_fill_tag   = entry_tag[i_mem_tag];
  assign o_fill_data  = i_mem_data;

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int t = 0; t < icache_pkg::NUM_MEM_TAGS; t++) begin
        entry_state[t] <= icache_pkg::TRANS_IDLE;
      end
    end else begin
      if (o_fill_en) begin
        entry_state[i_mem_tag] <= icache_pkg::TRANS_IDLE;
      end
      // A tag reused in its return cycle stays pending
      if (issue_en) begin
        entry_state[i_issue_tag] <= icache_pkg::TRANS_PENDING;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (issue_en) begin
      entry_index[i_issue_tag] <= i_issue_index;
      entry_tag[i_issue_tag]   <= i_issue_line_tag;
    end
  end

  // Memory must not hand out a tag that is still in flight
  a_issue_tag_free: assert property (
    @(posedge i_clock) disable iff (i_reset)
    (issue_en && i_issue_tag != i_mem_tag) |->
      entry_state[i_issue_tag] == icache_pkg::TRANS_IDLE
  ) else $error("mem_tag_table: tag %0d accepted while pending", i_issue_tag);

  // Data only ever comes back for a tag we are waiting on
  a_return_tag_pending: assert property (
    @(posedge i_clock) disable iff (i_reset)
    (i_mem_tag != '0) |-> entry_state[i_mem_tag] == icache_pkg::TRANS_PENDING
  ) else $error("mem_tag_table: data returned for idle tag %0d", i_mem_tag);

endmodule

// ==== prefetch_window.sv ====
`timescale 1ns/10ps

module prefetch_window (
  input  logic                                i_clock,
  input  logic                                i_reset,
  input  logic [icache_pkg::INDEX_W-1:0]      i_index,
  input  logic [icache_pkg::LINE_TAG_W-1:0]   i_line_tag,
  input  logic                                i_hit,
  input  logic [icache_pkg::MEM_TAG_W-1:0]    i_mem_response,
  output icache_pkg::mem_cmd_e                o_mem_command,
  output logic [icache_pkg::ADDR_W-1:0]       o_mem_addr,
  output logic [icache_pkg::INDEX_W-1:0]      o_issue_index,
  output logic [icache_pkg::LINE_TAG_W-1:0]   o_issue_line_tag,
  output logic [icache_pkg::MEM_TAG_W-1:0]    o_issue_tag
);

  logic [icache_pkg::LINE_ADDR_W-1:0] head_line;
  logic [icache_pkg::INDEX_W-1:0]     count;
  logic                               head_req;
  logic [icache_pkg::LINE_ADDR_W-1:0] cur_line;
  logic [icache_pkg::LINE_ADDR_W-1:0] step;
  logic [icache_pkg::LINE_ADDR_W-1:0] req_line;
  logic [icache_pkg::INDEX_W-1:0]     ahead;
  logic [icache_pkg::INDEX_W-1:0]     next_count;
  logic                               covered;
  logic                               cont;
  logic                               accepted;
  icache_pkg::mem_cmd_e               next_command;

  assign cur_line = {i_line_tag, i_index};

  // How far the fetch has moved since the last edge
  assign step = cur_line - head_line;

  // Current line already requested and still inside the window
  assign covered = head_req && (step <= icache_pkg::LINE_ADDR_W'(count));
  assign cont    = i_hit || covered;
  assign ahead   = covered ? count - step[icache_pkg::INDEX_W-1:0] : '0;

  assign accepted    = (o_mem_command == icache_pkg::BUS_LOAD) && (i_mem_response != '0);
  assign o_issue_tag = (o_mem_command == icache_pkg::BUS_LOAD) ? i_mem_response : '0;

  // The carry out of the index runs into the tag for wrapped lines
  always_comb begin
    if (cont) begin
      req_line = cur_line + icache_pkg::LINE_ADDR_W'(ahead) + icache_pkg::LINE_ADDR_W'(1);
    end else begin
      req_line = cur_line;
    end
  end

  assign o_mem_addr       = {req_line, {icache_pkg::OFFSET_W{1'b0}}};
  assign o_issue_index    = req_line[icache_pkg::INDEX_W-1:0];
  assign o_issue_line_tag = req_line[icache_pkg::LINE_ADDR_W-1 -: icache_pkg::LINE_TAG_W];

  assign next_count = cont ? ahead + icache_pkg::INDEX_W'(accepted) : '0;

  // Stop once the next line would land on head again
  assign next_command = (cont && next_count == icache_pkg::INDEX_W'(icache_pkg::NUM_LINES - 1)) ?
                        icache_pkg::BUS_NONE : icache_pkg::BUS_LOAD;

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      head_line     <= '0;
      count         <= '0;
      head_req      <= 1'b0;
      o_mem_command <= icache_pkg::BUS_NONE;
    end else begin
      head_line     <= cur_line;
      count         <= next_count;
      head_req      <= cont || accepted;
      o_mem_command <= next_command;
    end
  end

  // A full window must already have dropped its command
  a_window_no_wrap: assert property (
    @(posedge i_clock) disable iff (i_reset)
    (accepted && cont) |-> ahead != icache_pkg::INDEX_W'(icache_pkg::NUM_LINES - 1)
  ) else $error("prefetch_window: request accepted with full window");

endmodule

// ==== icache_top.sv ====
`timescale 1ns/10ps

module icache_top (
  input  logic                                clock,
  input  logic                                reset,
  input  logic [icache_pkg::ADDR_W-1:0]       i_proc_addr,
  output logic [icache_pkg::DATA_W-1:0]       o_data,
  output logic                                o_valid,
  output icache_pkg::mem_cmd_e                o_mem_command,
  output logic [icache_pkg::ADDR_W-1:0]       o_mem_addr,
  input  logic [icache_pkg::MEM_TAG_W-1:0]    i_mem_response,
  input  logic [icache_pkg::DATA_W-1:0]       i_mem_data,
  input  logic [icache_pkg::MEM_TAG_W-1:0]    i_mem_tag
);

  logic [icache_pkg::INDEX_W-1:0]    lookup_index;
  logic [icache_pkg::LINE_TAG_W-1:0] lookup_line_tag;
  logic [icache_pkg::INDEX_W-1:0]    issue_index;
  logic [icache_pkg::LINE_TAG_W-1:0] issue_line_tag;
  logic [icache_pkg::MEM_TAG_W-1:0]  issue_tag;
  logic                              fill_en;
  logic [icache_pkg::INDEX_W-1:0]    fill_index;
  logic [icache_pkg::LINE_TAG_W-1:0] fill_tag;
  logic [icache_pkg::DATA_W-1:0]     fill_data;

  icache_lines u_lines (
    .i_clock          (clock),
    .i_reset          (reset),
    .i_lookup_addr    (i_proc_addr),
    .i_issue_tag      (issue_tag),
    .i_issue_index    (issue_index),
    .i_issue_line_tag (issue_line_tag),
    .i_fill_en        (fill_en),
    .i_fill_index     (fill_index),
    .i_fill_tag       (fill_tag),
    .i_fill_data      (fill_data),
    .o_index          (lookup_index),
    .o_line_tag       (lookup_line_tag),
    .o_hit            (o_valid),
    .o_data           (o_data)
  );

  mem_tag_table u_tag_table (
    .i_clock          (clock),
    .i_reset          (reset),
    .i_issue_tag      (issue_tag),
    .i_issue_index    (issue_index),
    .i_issue_line_tag (issue_line_tag),
    .i_mem_tag        (i_mem_tag),
    .i_mem_data       (i_mem_data),
    .o_fill_en        (fill_en),
    .o_fill_index     (fill_index),
    .o_fill_tag       (fill_tag),
    .o_fill_data      (fill_data)
  );

  prefetch_window u_window (
    .i_clock          (clock),
    .i_reset          (reset),
    .i_index          (lookup_index),
    .i_line_tag       (lookup_line_tag),
    .i_hit            (o_valid),
    .i_mem_response   (i_mem_response),
    .o_mem_command    (o_mem_command),
    .o_mem_addr       (o_mem_addr),
    .o_issue_index    (issue_index),
    .o_issue_line_tag (issue_line_tag),
    .o_issue_tag      (issue_tag)
  );

endmodule

// ==== tb_imem_model.sv ====
`timescale 1ns/10ps

module tb_imem_model (
  input  logic                             i_clock,
  input  logic                             i_reset,
  input  logic                             i_refuse,
  input  icache_pkg::mem_cmd_e             i_mem_command,
  input  logic [icache_pkg::ADDR_W-1:0]    i_mem_addr,
  output logic [icache_pkg::MEM_TAG_W-1:0] o_mem_response,
  output logic [icache_pkg::DATA_W-1:0]    o_mem_data,
  output logic [icache_pkg::MEM_TAG_W-1:0] o_mem_tag,
  output int                               o_in_flight,
  output int                               o_error_count
);

  localparam int LATENCY = 6;
  localparam int ACCEPT_PERCENT = 70;

  logic [31:0]                         rng;
  logic [icache_pkg::NUM_MEM_TAGS-1:0] tag_busy;
  logic                                refusing;
  int                                  cycle;
  int                                  due_q[$];
  logic [icache_pkg::MEM_TAG_W-1:0]    tag_q[$];
  logic [icache_pkg::ADDR_W-1:0]       addr_q[$];
  int                                  refuse_errors = 0;
  int                                  tag_errors = 0;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] v;
    v = x ^ (x << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Line-aligned address followed by its inverse
  function automatic logic [icache_pkg::DATA_W-1:0] line_word(
    input logic [icache_pkg::ADDR_W-1:0] addr
  );
    logic [icache_pkg::ADDR_W-1:0] base;
    base = {addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W], {icache_pkg::OFFSET_W{1'b0}}};
    return {base, ~base};
  endfunction

  function automatic logic [icache_pkg::MEM_TAG_W-1:0] lowest_free_tag(
    input logic [icache_pkg::NUM_MEM_TAGS-1:0] busy
  );
    logic [icache_pkg::MEM_TAG_W-1:0] found;
    found = '0;
    for (int t = icache_pkg::NUM_MEM_TAGS - 1; t > 0; t--) begin
      if (!busy[t]) begin
        found = icache_pkg::MEM_TAG_W'(t);
      end
    end
    return found;
  endfunction

  assign o_error_count = refuse_errors + tag_errors;

  // Accept decision and returning data change on the falling edge
  initial begin
    o_mem_response = '0;
    o_mem_data = '0;
    o_mem_tag = '0;
    rng = 32'ha910;
    forever begin
      @(negedge i_clock);
      rng = xorshift32(rng);
      if (!i_reset && !refusing && i_mem_command == icache_pkg::BUS_LOAD &&
          rng % 100 < ACCEPT_PERCENT) begin
        o_mem_response = lowest_free_tag(tag_busy);
      end else begin
        o_mem_response = '0;
      end
      // Oldest load goes out first and later ones slip a cycle on a collision
      if (!i_reset && due_q.size() > 0 && due_q[0] <= cycle + 1) begin
        o_mem_tag = tag_q[0];
        o_mem_data = line_word(addr_q[0]);
      end else begin
        o_mem_tag = '0;
        o_mem_data = '0;
      end
    end
  end

  initial begin
    tag_busy = '0;
    refusing = 1'b0;
    cycle = 0;
    o_in_flight = 0;
    forever begin
      @(posedge i_clock);
      if (i_reset) begin
        tag_busy = '0;
        cycle = 0;
        due_q.delete();
        tag_q.delete();
        addr_q.delete();
      end else begin
        cycle++;
        if (o_mem_tag != '0) begin
          tag_busy[o_mem_tag] = 1'b0;
          void'(due_q.pop_front());
          void'(tag_q.pop_front());
          void'(addr_q.pop_front());
        end
        if (i_mem_command == icache_pkg::BUS_LOAD && o_mem_response != '0) begin
          tag_busy[o_mem_response] = 1'b1;
          due_q.push_back(cycle + LATENCY);
          tag_q.push_back(o_mem_response);
          addr_q.push_back(i_mem_addr);
        end
      end
      refusing = i_refuse;
      o_in_flight = due_q.size();
    end
  end

  // A refused load is asked for again on the next cycle
  a_refused_load_retried: assert property (
    @(posedge i_clock) disable iff (i_reset)
    refusing |-> i_mem_command == icache_pkg::BUS_LOAD
  ) else begin
    refuse_errors++;
    $display("mismatch at %0t: o_mem_command expected %0d actual %0d while refusing",
             $time, icache_pkg::BUS_LOAD, $sampled(i_mem_command));
  end

  a_return_known_tag: assert property (
    @(posedge i_clock) disable iff (i_reset) (o_mem_tag != '0) |-> tag_busy[o_mem_tag]
  ) else begin
    tag_errors++;
    $display("memory model returned data at %0t for tag %0d that was never handed out",
             $time, o_mem_tag);
  end

endmodule

// ==== icache_tb.sv ====
`timescale 1ns/10ps

module icache_tb;

  localparam int TIMEOUT_CYCLES = 400;
  localparam int RESET_CYCLES = 16;
  localparam int REFUSE_CYCLES = 30;
  localparam int REDIRECT_ROUNDS = 4;
  localparam logic [31:0] PREFETCH_BASE = 32'h0000_1028;
  localparam logic [31:0] REFUSE_ADDR = 32'h0040_2204;
  localparam logic [31:0] REDIRECT_ADDR = 32'h0000_3a10;
  localparam logic [31:0] TAG_FLIP = 32'h0008_0000;

  logic                             clock;
  logic                             reset;
  logic [icache_pkg::ADDR_W-1:0]    proc_addr;
  logic [icache_pkg::DATA_W-1:0]    fetch_data;
  logic                             fetch_valid;
  icache_pkg::mem_cmd_e             mem_command;
  logic [icache_pkg::ADDR_W-1:0]    mem_addr;
  logic [icache_pkg::MEM_TAG_W-1:0] mem_response;
  logic [icache_pkg::DATA_W-1:0]    mem_data;
  logic [icache_pkg::MEM_TAG_W-1:0] mem_tag;
  logic                             refuse;
  logic                             expect_hit;
  logic [icache_pkg::DATA_W-1:0]    expect_word;
  logic [31:0]                      stim_state;
  int                               in_flight;
  int                               model_errors;
  int                               reset_cmd_errors = 0;
  int                               reset_hit_errors = 0;
  int                               data_errors = 0;
  int                               hit_errors = 0;
  int                               timeout_count = 0;
  int                               tests_run = 0;
  int                               tests_failed = 0;
  int                               test_start_errors = 0;

  icache_top UUT (
    .clock          (clock),
    .reset          (reset),
    .i_proc_addr    (proc_addr),
    .o_data         (fetch_data),
    .o_valid        (fetch_valid),
    .o_mem_command  (mem_command),
    .o_mem_addr     (mem_addr),
    .i_mem_response (mem_response),
    .i_mem_data     (mem_data),
    .i_mem_tag      (mem_tag)
  );

  tb_imem_model u_mem (
    .i_clock        (clock),
    .i_reset        (reset),
    .i_refuse       (refuse),
    .i_mem_command  (mem_command),
    .i_mem_addr     (mem_addr),
    .o_mem_response (mem_response),
    .o_mem_data     (mem_data),
    .o_mem_tag      (mem_tag),
    .o_in_flight    (in_flight),
    .o_error_count  (model_errors)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] v;
    v = x ^ (x << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic logic [icache_pkg::DATA_W-1:0] line_word(
    input logic [icache_pkg::ADDR_W-1:0] addr
  );
    logic [icache_pkg::ADDR_W-1:0] base;
    base = {addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W], {icache_pkg::OFFSET_W{1'b0}}};
    return {base, ~base};
  endfunction

  function automatic int error_total();
    return reset_cmd_errors + reset_hit_errors + data_errors + hit_errors +
           timeout_count + model_errors;
  endfunction

  assign expect_word = line_word(proc_addr);

  // 40 ns period
  initial clock = 1'b0;
  always #20 clock = ~clock;

  a_reset_command: assert property (
    @(posedge clock) $fell(reset) |-> mem_command == icache_pkg::BUS_NONE
  ) else begin
    reset_cmd_errors++;
    $display("mismatch at %0t: o_mem_command expected %0d actual %0d",
             $time, icache_pkg::BUS_NONE, $sampled(mem_command));
  end

  a_reset_no_hit: assert property (
    @(posedge clock) $fell(reset) |-> !fetch_valid
  ) else begin
    reset_hit_errors++;
    $display("mismatch at %0t: o_valid expected 0 actual %b", $time, $sampled(fetch_valid));
  end

  a_data_matches: assert property (
    @(posedge clock) disable iff (reset) fetch_valid |-> fetch_data == expect_word
  ) else begin
    data_errors++;
    $display("mismatch at %0t: o_data expected %h actual %h",
             $time, $sampled(expect_word), $sampled(fetch_data));
  end

  a_prefetched_hit: assert property (
    @(posedge clock) disable iff (reset) expect_hit |-> fetch_valid
  ) else begin
    hit_errors++;
    $display("mismatch at %0t: o_valid expected 1 actual %b for address %h",
             $time, $sampled(fetch_valid), $sampled(proc_addr));
  end

  task automatic next_address(output logic [31:0] addr);
    stim_state = xorshift32(stim_state);
    addr = stim_state;
  endtask

  task automatic wait_for_valid(input string what);
    int n;
    n = 0;
    @(negedge clock);
    while (!fetch_valid && n < TIMEOUT_CYCLES) begin
      @(negedge clock);
      n++;
    end
    if (!fetch_valid) begin
      timeout_count++;
      $display("timeout: no hit on the %s within %0d cycles", what, TIMEOUT_CYCLES);
    end
  endtask

  // Window is full once the command has stayed idle for two cycles
  task automatic wait_for_window_full();
    int n;
    int idle_run;
    n = 0;
    idle_run = 0;
    while (idle_run < 2 && n < TIMEOUT_CYCLES) begin
      @(negedge clock);
      n++;
      if (mem_command == icache_pkg::BUS_NONE) begin
        idle_run++;
      end else begin
        idle_run = 0;
      end
    end
    if (idle_run < 2) begin
      timeout_count++;
      $display("timeout: memory command never went idle with a full window");
    end
  endtask

  task automatic wait_for_memory_idle();
    int n;
    n = 0;
    while (in_flight != 0 && n < TIMEOUT_CYCLES) begin
      @(negedge clock);
      n++;
    end
    if (in_flight != 0) begin
      timeout_count++;
      $display("timeout: %0d loads still outstanding at the memory", in_flight);
    end
  endtask

  task automatic start_test();
    test_start_errors = error_total();
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = error_total() - test_start_errors;
    tests_run++;
    if (errs == 0) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errs);
    end
  endtask

  initial begin
    logic [31:0] addr;
    logic [31:0] other;
    reset = 1'b1;
    refuse = 1'b0;
    expect_hit = 1'b0;
    stim_state = 32'ha910;
    next_address(addr);
    proc_addr = addr;

    start_test();
    repeat (RESET_CYCLES) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    finish_test("reset state");

    start_test();
    wait_for_valid("cold start address");
    finish_test("miss service");

    // Base sits at index 5, so later lines wrap into the next tag
    start_test();
    proc_addr = PREFETCH_BASE;
    wait_for_window_full();
    wait_for_memory_idle();
    for (int k = 1; k < icache_pkg::NUM_LINES; k++) begin
      @(negedge clock);
      proc_addr = PREFETCH_BASE + icache_pkg::ADDR_W'(k << icache_pkg::OFFSET_W);
      expect_hit = 1'b1;
    end
    @(negedge clock);
    expect_hit = 1'b0;
    finish_test("prefetch fill");

    start_test();
    refuse = 1'b1;
    proc_addr = REFUSE_ADDR;
    repeat (REFUSE_CYCLES) @(negedge clock);
    refuse = 1'b0;
    wait_for_valid("address held through refusal");
    finish_test("back-pressure");

    // Same index under a new tag while the old fills are still out
    start_test();
    proc_addr = REDIRECT_ADDR;
    repeat (3) @(negedge clock);
    proc_addr = REDIRECT_ADDR ^ TAG_FLIP;
    wait_for_valid("same-index redirect");
    for (int r = 0; r < REDIRECT_ROUNDS; r++) begin
      next_address(addr);
      next_address(other);
      proc_addr = addr;
      repeat (4) @(negedge clock);
      proc_addr = other;
      wait_for_valid("redirect target");
      proc_addr = addr;
      wait_for_valid("address before the redirect");
    end
    finish_test("redirect");

    $display("tests run %0d, tests failed %0d, errors %0d",
             tests_run, tests_failed, error_total());
    if (tests_failed == 0 && error_total() == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
icache_pkg.sv
icache_lines.sv
mem_tag_table.sv
prefetch_window.sv
icache_top.sv
tb_imem_model.sv
icache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module icache_tb \
  -f verilog.f \
  -o icache_sim > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/icache_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$SIM_LOG"; then
  exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$SIM_LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
